//--- compile.f
+incdir+test
logic/prefetch_pkg.sv
logic/cache_load_port.sv
logic/stbuf_load_port.sv
logic/slice_sequencer.sv
logic/prefetcher_top.sv
test/prefetcher_tb.sv

//--- logic/cache_load_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one cache load in flight; ready_i counts only while wait_i is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module cache_load_port (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_i,
	input  prefetch_pkg::word_t addr_i,
	input  logic                wait_i,
	input  logic                ready_i,
	input  prefetch_pkg::word_t mem_data_i,
	output logic                req_o,
	output prefetch_pkg::word_t addr_o,
	output prefetch_pkg::word_t data_o,
	output logic                busy_o
);
	import prefetch_pkg::*;

	logic  req_q;
	word_t addr_q;
	word_t data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
			addr_q <= '0;
			data_q <= '0;
		end else if (wait_i) begin
			// cache has taken the request, drop it
			req_q <= 1'b0;
			if (ready_i) begin
				data_q <= mem_data_i;
			end
		end else if (issue_i) begin
			req_q <= 1'b1;
			addr_q <= addr_i;
		end
	end

	assign req_o = req_q;
	assign addr_o = addr_q;
	assign data_o = data_q;

	// the sequencer freezes on this level
	assign busy_o = wait_i;

	// a request never survives a stalled cycle
	req_after_stall_a: assert property (
		@(posedge clk) disable iff (reset)
		$past(wait_i) |-> !req_o
	);

endmodule

//--- logic/prefetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte addresses, one 32-bit word per offset
// stack and argument layout are fixed by the kernel slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package prefetch_pkg;

	localparam int WORD_W = 32;
	localparam int NUM_REGS = 16;
	localparam int REG_IDX_W = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// register roles in the slice
	localparam reg_idx_t SP_REG = 4'd13;
	localparam reg_idx_t FP_REG = 4'd11;
	localparam reg_idx_t SL_REG = 4'd10;

	// stack frame offsets from sp
	localparam word_t OFS_ROW_CNT = 32'd4;
	localparam word_t OFS_ROW_PTR = 32'd8;
	localparam word_t OFS_ARG = 32'd16;
	localparam word_t OFS_REMAIN = 32'd20;

	// offsets inside the argument block
	localparam word_t OFS_COLIDX = 32'd4;
	localparam word_t OFS_ROWPTR = 32'd8;
	localparam word_t OFS_LIMIT = 32'd16;

	// one state per basic block of the slice
	typedef enum logic [3:0] {
		ST_IDLE = 4'd0,
		ST_SETUP = 4'd1,
		ST_ROW_START = 4'd2,
		ST_INNER = 4'd3,
		ST_ROW_END = 4'd4,
		ST_NEXT_ROW = 4'd5,
		ST_COUNT_DOWN = 4'd6,
		ST_DONE = 4'd7
	} slice_state_e;

	// instruction slot within a block
	typedef logic [2:0] step_t;

endpackage

//--- logic/prefetcher_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger is a single-cycle pulse; wait levels stall all progress
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module prefetcher_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       trigger_i,
	input  logic                       wait_cache_i,
	input  logic                       wait_stbuf_i,
	input  logic                       cache_ready_i,
	input  logic                       stbuf_ready_i,
	input  prefetch_pkg::word_t        cache_data_i,
	input  prefetch_pkg::word_t        stbuf_data_i,
	output logic                       cache_req_o,
	output prefetch_pkg::word_t        cache_addr_o,
	output logic                       stbuf_req_o,
	output prefetch_pkg::word_t        stbuf_addr_o,
	output prefetch_pkg::word_t        wr_addr_o,
	output prefetch_pkg::word_t        wr_data_o,
	output prefetch_pkg::slice_state_e state_o
);
	import prefetch_pkg::*;

	logic  cache_issue;
	logic  stbuf_issue;
	logic  cache_busy;
	logic  stbuf_busy;
	word_t cache_issue_addr;
	word_t stbuf_issue_addr;
	word_t cache_word;
	word_t stbuf_word;

	cache_load_port u_cache_port (
		.clk        (clk),
		.reset      (reset),
		.issue_i    (cache_issue),
		.addr_i     (cache_issue_addr),
		.wait_i     (wait_cache_i),
		.ready_i    (cache_ready_i),
		.mem_data_i (cache_data_i),
		.req_o      (cache_req_o),
		.addr_o     (cache_addr_o),
		.data_o     (cache_word),
		.busy_o     (cache_busy)
	);

	stbuf_load_port u_stbuf_port (
		.clk        (clk),
		.reset      (reset),
		.issue_i    (stbuf_issue),
		.addr_i     (stbuf_issue_addr),
		.wait_i     (wait_stbuf_i),
		.ready_i    (stbuf_ready_i),
		.mem_data_i (stbuf_data_i),
		.req_o      (stbuf_req_o),
		.addr_o     (stbuf_addr_o),
		.data_o     (stbuf_word),
		.busy_o     (stbuf_busy)
	);

	slice_sequencer u_seq (
		.clk           (clk),
		.reset         (reset),
		.trigger_i     (trigger_i),
		.stall_cache_i (cache_busy),
		.stall_stbuf_i (stbuf_busy),
		.cache_word_i  (cache_word),
		.stbuf_word_i  (stbuf_word),
		.cache_issue_o (cache_issue),
		.cache_addr_o  (cache_issue_addr),
		.stbuf_issue_o (stbuf_issue),
		.stbuf_addr_o  (stbuf_issue_addr),
		.wr_addr_o     (wr_addr_o),
		.wr_data_o     (wr_data_o),
		.state_o       (state_o)
	);

endmodule

//--- logic/slice_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs the spmv slice once per trigger; loaded words are used
// one step after issue, ST_DONE is left only by reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module slice_sequencer (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       trigger_i,
	input  logic                       stall_cache_i,
	input  logic                       stall_stbuf_i,
	input  prefetch_pkg::word_t        cache_word_i,
	input  prefetch_pkg::word_t        stbuf_word_i,
	output logic                       cache_issue_o,
	output prefetch_pkg::word_t        cache_addr_o,
	output logic                       stbuf_issue_o,
	output prefetch_pkg::word_t        stbuf_addr_o,
	output prefetch_pkg::word_t        wr_addr_o,
	output prefetch_pkg::word_t        wr_data_o,
	output prefetch_pkg::slice_state_e state_o
);
	import prefetch_pkg::*;

	word_t        rf [NUM_REGS];
	slice_state_e state_q;
	step_t        step_q;
	logic         stall;
	logic         cache_ld;
	logic         stbuf_ld;
	word_t        sp;

	assign stall = stall_cache_i | stall_stbuf_i;
	assign sp = rf[SP_REG];
	assign state_o = state_q;

	// loads of the current step, issued only when nothing is pending
	always_comb begin
		cache_ld = 1'b0;
		cache_addr_o = '0;
		stbuf_ld = 1'b0;
		stbuf_addr_o = '0;
		case (state_q)
			ST_SETUP: begin
				case (step_q)
					3'd0: begin
						// argument block pointer
						cache_ld = 1'b1;
						cache_addr_o = sp + OFS_ARG;
					end
					3'd1, 3'd2: begin
						// two pointer chases
						cache_ld = 1'b1;
						cache_addr_o = cache_word_i;
					end
					3'd3: begin
						cache_ld = 1'b1;
						cache_addr_o = rf[0] + OFS_ROWPTR;
					end
					default: ;
				endcase
			end
			ST_ROW_START: begin
				if (step_q == 3'd0) begin
					cache_ld = 1'b1;
					cache_addr_o = rf[FP_REG] + (rf[3] << 2);
				end else if (step_q == 3'd1) begin
					cache_ld = 1'b1;
					cache_addr_o = rf[0] + OFS_COLIDX;
				end
			end
			ST_INNER: begin
				case (step_q)
					3'd1: begin
						cache_ld = 1'b1;
						cache_addr_o = rf[9] + rf[1];
					end
					3'd2: begin
						// the delinquent load, indexed by the fresh column
						cache_ld = 1'b1;
						cache_addr_o = rf[2] + (cache_word_i << 2);
					end
					3'd3: begin
						cache_ld = 1'b1;
						cache_addr_o = rf[0] + OFS_LIMIT;
					end
					3'd4: begin
						cache_ld = 1'b1;
						cache_addr_o = rf[SL_REG];
					end
					default: ;
				endcase
			end
			ST_ROW_END: begin
				if (step_q == 3'd0) begin
					// store buffer holds the row count, safe to pair
					cache_ld = 1'b1;
					cache_addr_o = sp + OFS_ARG;
					stbuf_ld = 1'b1;
					stbuf_addr_o = sp + OFS_ROW_CNT;
				end else if (step_q == 3'd1) begin
					cache_ld = 1'b1;
					cache_addr_o = cache_word_i + OFS_ROWPTR;
				end
			end
			ST_NEXT_ROW: begin
				if (step_q == 3'd0) begin
					stbuf_ld = 1'b1;
					stbuf_addr_o = sp + OFS_ROW_PTR;
					cache_ld = 1'b1;
					cache_addr_o = rf[1] + OFS_COLIDX;
				end
			end
			ST_COUNT_DOWN: begin
				if (step_q == 3'd0) begin
					stbuf_ld = 1'b1;
					stbuf_addr_o = sp + OFS_REMAIN;
				end
			end
			default: ;
		endcase
	end

	assign cache_issue_o = cache_ld & ~stall;
	assign stbuf_issue_o = stbuf_ld & ~stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= ST_IDLE;
			step_q <= '0;
			wr_addr_o <= '0;
			wr_data_o <= '0;
			for (int i = 0; i < NUM_REGS; i++) begin
				rf[i] <= '0;
			end
		end else if (!stall) begin
			case (state_q)
				ST_IDLE: begin
					if (trigger_i) begin
						// each register starts as its own index
						for (int i = 0; i < NUM_REGS; i++) begin
							rf[i] <= word_t'(i);
						end
						state_q <= ST_SETUP;
						step_q <= '0;
					end
				end
				ST_SETUP: begin
					case (step_q)
						3'd0: begin
							step_q <= 3'd1;
						end
						3'd1: begin
							rf[1] <= '0;
							step_q <= 3'd2;
						end
						3'd2: begin
							rf[6] <= cache_word_i;
							wr_addr_o <= sp + OFS_ROW_CNT;
							wr_data_o <= rf[1];
							step_q <= 3'd3;
						end
						3'd3: begin
							rf[3] <= cache_word_i;
							wr_addr_o <= sp + OFS_ROW_PTR;
							wr_data_o <= rf[6];
							step_q <= 3'd4;
						end
						3'd4: begin
							rf[FP_REG] <= cache_word_i;
							state_q <= ST_ROW_START;
							step_q <= '0;
						end
						default: begin
							state_q <= ST_IDLE;
							step_q <= '0;
						end
					endcase
				end
				ST_ROW_START: begin
					case (step_q)
						3'd0: begin
							rf[7] <= rf[3] + 32'd1;
							step_q <= 3'd1;
						end
						3'd1: begin
							rf[3] <= cache_word_i;
							rf[8] <= cache_word_i << 2;
							rf[SL_REG] <= rf[FP_REG] + (rf[7] << 2);
							step_q <= 3'd2;
						end
						3'd2: begin
							// r1 ends at zero, the load only feeds r9
							rf[9] <= cache_word_i + rf[8];
							rf[1] <= '0;
							// block ends on an unconditional jump past the increment
							state_q <= ST_INNER;
							step_q <= 3'd1;
						end
						default: begin
							state_q <= ST_IDLE;
							step_q <= '0;
						end
					endcase
				end
				ST_INNER: begin
					case (step_q)
						3'd0: begin
							rf[1] <= rf[1] + 32'd4;
							step_q <= 3'd1;
						end
						3'd1: begin
							step_q <= 3'd2;
						end
						3'd2: begin
							rf[4] <= cache_word_i;
							step_q <= 3'd3;
						end
						3'd3: begin
							rf[5] <= cache_word_i;
							step_q <= 3'd4;
						end
						3'd4: begin
							rf[4] <= cache_word_i;
							rf[3] <= rf[3] + 32'd1;
							step_q <= 3'd5;
						end
						3'd5: begin
							rf[5] <= cache_word_i;
							// loop while below the row bound
							state_q <= (rf[3] < cache_word_i) ? ST_INNER : ST_ROW_END;
							step_q <= '0;
						end
						default: begin
							state_q <= ST_IDLE;
							step_q <= '0;
						end
					endcase
				end
				ST_ROW_END: begin
					case (step_q)
						3'd0: begin
							step_q <= 3'd1;
						end
						3'd1: begin
							rf[3] <= cache_word_i;
							rf[1] <= stbuf_word_i + 32'd1;
							step_q <= 3'd2;
						end
						3'd2: begin
							rf[5] <= cache_word_i;
							wr_addr_o <= sp + OFS_ROW_CNT;
							wr_data_o <= rf[1];
							state_q <= (rf[1] >= cache_word_i) ? ST_COUNT_DOWN : ST_NEXT_ROW;
							step_q <= '0;
						end
						default: begin
							state_q <= ST_IDLE;
							step_q <= '0;
						end
					endcase
				end
				ST_NEXT_ROW: begin
					case (step_q)
						3'd0: begin
							step_q <= 3'd1;
						end
						3'd1: begin
							rf[1] <= stbuf_word_i;
							rf[3] <= cache_word_i;
							wr_addr_o <= sp + OFS_ROW_PTR;
							wr_data_o <= stbuf_word_i;
							state_q <= (cache_word_i <= rf[4]) ? ST_ROW_START : ST_COUNT_DOWN;
							step_q <= '0;
						end
						default: begin
							state_q <= ST_IDLE;
							step_q <= '0;
						end
					endcase
				end
				ST_COUNT_DOWN: begin
					case (step_q)
						3'd0: begin
							step_q <= 3'd1;
						end
						3'd1: begin
							rf[3] <= stbuf_word_i - 32'd1;
							wr_addr_o <= sp + OFS_REMAIN;
							wr_data_o <= stbuf_word_i - 32'd1;
							// outer exit compares row count with its limit
							state_q <= (rf[1] != rf[5]) ? ST_SETUP : ST_DONE;
							step_q <= '0;
						end
						default: begin
							state_q <= ST_IDLE;
							step_q <= '0;
						end
					endcase
				end
				ST_DONE: begin
					state_q <= ST_DONE;
				end
				default: begin
					state_q <= ST_IDLE;
					step_q <= '0;
				end
			endcase
		end
	end

	// nothing issues under stall, and the step is frozen for it
	stall_freeze_a: assert property (
		@(posedge clk) disable iff (reset)
		stall |-> (!cache_issue_o && !stbuf_issue_o) ##1 ($stable(state_q) && $stable(step_q))
	);

	done_sticky_a: assert property (
		@(posedge clk) disable iff (reset)
		state_q == ST_DONE |=> state_q == ST_DONE
	);

endmodule

//--- logic/stbuf_load_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one store-buffer load in flight; may run beside a cache load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module stbuf_load_port (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_i,
	input  prefetch_pkg::word_t addr_i,
	input  logic                wait_i,
	input  logic                ready_i,
	input  prefetch_pkg::word_t mem_data_i,
	output logic                req_o,
	output prefetch_pkg::word_t addr_o,
	output prefetch_pkg::word_t data_o,
	output logic                busy_o
);
	import prefetch_pkg::*;

	logic  req_q;
	word_t addr_q;
	word_t data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
			addr_q <= '0;
			data_q <= '0;
		end else if (wait_i) begin
			// store buffer is looking up, request goes low
			req_q <= 1'b0;
			if (ready_i) begin
				data_q <= mem_data_i;
			end
		end else if (issue_i) begin
			req_q <= 1'b1;
			addr_q <= addr_i;
		end
	end

	assign req_o = req_q;
	assign addr_o = addr_q;
	assign data_o = data_q;

	// stall level straight through to the sequencer
	assign busy_o = wait_i;

	// request low on every cycle after a stall
	req_after_stall_a: assert property (
		@(posedge clk) disable iff (reset)
		$past(wait_i) |-> !req_o
	);

endmodule

//--- test/prefetcher_tests.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tasks run in order on one DUT and one triggered run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PREFETCHER_TESTS_SVH
`define PREFETCHER_TESTS_SVH

task automatic idle_after_reset();
	if (state_o !== ST_IDLE) begin
		report_mismatch("state after reset", state_o, ST_IDLE);
	end
	repeat (50) begin
		if (cache_req_o !== 1'b0 || stbuf_req_o !== 1'b0) begin
			report_mismatch("requests while idle", {cache_req_o, stbuf_req_o}, 0);
		end
		@(negedge clk);
	end
endtask

task automatic start_on_trigger();
	int n;
	trigger_i = 1'b1;
	@(negedge clk);
	trigger_i = 1'b0;
	while (state_o !== ST_SETUP && n < 20) begin
		@(negedge clk);
		n++;
	end
	if (state_o !== ST_SETUP) begin
		report_timeout("ST_SETUP after the trigger");
	end
	wait_cache_req("the first cache request");
	if (cache_addr_o !== SP_SEED + OFS_ARG) begin
		report_mismatch("first cache address", cache_addr_o, SP_SEED + OFS_ARG);
	end
endtask

// entered on the cycle the first request shows
task automatic hold_under_stall();
	slice_state_e held_state;
	held_state = state_o;
	extra_stall = 1'b1;
	repeat (8) begin
		@(negedge clk);
		if (cache_req_o !== 1'b0) begin
			report_mismatch("cache request under stall", cache_req_o, 0);
		end
		if (state_o !== held_state) begin
			report_mismatch("state under stall", state_o, held_state);
		end
	end
	extra_stall = 1'b0;
	wait_cache_req("the request after the stall");
	// pointer chase through the argument slot
	if (cache_addr_o !== model_word(SP_SEED + OFS_ARG)) begin
		report_mismatch("address after stall", cache_addr_o, model_word(SP_SEED + OFS_ARG));
	end
endtask

task automatic setup_store_pair();
	word_t chased;
	chased = model_word(model_word(SP_SEED + OFS_ARG));
	wait_write_change(32'd0, "the first write");
	if (wr_addr_o !== SP_SEED + OFS_ROW_CNT) begin
		report_mismatch("first write address", wr_addr_o, SP_SEED + OFS_ROW_CNT);
	end
	if (wr_data_o !== 32'd0) begin
		report_mismatch("first write data", wr_data_o, 32'd0);
	end
	wait_write_change(wr_addr_o, "the second write");
	if (wr_addr_o !== SP_SEED + OFS_ROW_PTR) begin
		report_mismatch("second write address", wr_addr_o, SP_SEED + OFS_ROW_PTR);
	end
	if (wr_data_o !== chased) begin
		report_mismatch("second write data", wr_data_o, chased);
	end
endtask

task automatic run_to_done();
	int n;
	int group;
	int pairs;
	word_t col_target;
	while (state_o !== ST_DONE && n < 20000) begin
		@(negedge clk);
		n++;
		if (stbuf_req_o === 1'b1 && stbuf_addr_o !== SP_SEED + OFS_ROW_CNT
				&& stbuf_addr_o !== SP_SEED + OFS_ROW_PTR
				&& stbuf_addr_o !== SP_SEED + OFS_REMAIN) begin
			errors++;
			$display("[ERROR] %0t: store-buffer request at %0d is no stack slot",
				$time, stbuf_addr_o);
		end
		if (cache_req_o === 1'b1 && state_o !== ST_INNER) begin
			group = 0;
		end else if (cache_req_o === 1'b1) begin
			// four loads per inner pass with the column index first
			if (group % 4 == 0) begin
				col_target = 32'd2 + (model_word(cache_addr_o) << 2);
			end else if (group % 4 == 1) begin
				pairs++;
				if (cache_addr_o !== col_target) begin
					report_mismatch("column-indexed address", cache_addr_o, col_target);
				end
			end
			group++;
		end
	end
	if (state_o !== ST_DONE) begin
		report_timeout("ST_DONE");
	end else if (pairs == 0) begin
		errors++;
		$display("the run reached ST_DONE without any column-indexed load");
	end
	repeat (20) begin
		@(negedge clk);
		if (state_o !== ST_DONE) begin
			report_mismatch("state after done", state_o, ST_DONE);
		end
	end
endtask

`endif

//--- test/prefetcher_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// each load stalls two cycles and model words stay below 65
// the row limit is set so one row ends the slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module prefetcher_tb;
	import prefetch_pkg::*;

	localparam int MEM_WORDS = 1024;
	// registers are seeded with their index
	localparam word_t SP_SEED = 32'd13;

	logic         clk;
	logic         reset;
	logic         trigger_i;
	logic         cache_wait;
	logic         extra_stall;
	logic         wait_cache_i;
	logic         wait_stbuf_i;
	logic         cache_ready_i;
	logic         stbuf_ready_i;
	word_t        cache_data_i;
	word_t        stbuf_data_i;
	logic         cache_req_o;
	word_t        cache_addr_o;
	logic         stbuf_req_o;
	word_t        stbuf_addr_o;
	word_t        wr_addr_o;
	word_t        wr_data_o;
	slice_state_e state_o;
	word_t        mem [MEM_WORDS];
	word_t        cache_held;
	word_t        stbuf_held;
	int           errors;
	int           timeouts;

	assign wait_cache_i = cache_wait | extra_stall;

	prefetcher_top DUT (.*);

	initial begin
		clk = 1'b1;
		forever #10 clk = ~clk;
	end

	function automatic word_t lcg_next(input word_t s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic word_t model_word(input word_t addr);
		if (addr < MEM_WORDS) begin
			return mem[addr];
		end
		return '0;
	endfunction

	task automatic fill_model();
		word_t rng;
		word_t arg;
		rng = 32'h303bc1e8;
		for (int i = 0; i < MEM_WORDS; i++) begin
			rng = lcg_next(rng);
			mem[i] = (rng >> 16) & 32'd63;
		end
		// argument block sits above the stack slots
		mem[29] = 32'd32 | (mem[29] & 32'd31);
		arg = mem[29];
		// limit one past the saved row count ends the outer loop
		mem[arg + OFS_ROWPTR] = mem[SP_SEED + OFS_ROW_CNT] + 32'd1;
	endtask

	task automatic report_mismatch(input string what, input word_t got, input word_t exp);
		errors++;
		$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic wait_cache_req(input string what);
		int n;
		while (cache_req_o !== 1'b1 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (cache_req_o !== 1'b1) begin
			report_timeout(what);
		end
	endtask

	task automatic wait_write_change(input word_t old_addr, input string what);
		int n;
		while (wr_addr_o === old_addr && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (wr_addr_o === old_addr) begin
			report_timeout(what);
		end
	endtask

	// cache responder stalls at once and returns data one cycle later
	always begin
		@(negedge clk);
		if (cache_req_o === 1'b1) begin
			cache_wait = 1'b1;
			cache_held = cache_addr_o;
			@(negedge clk);
			cache_ready_i = 1'b1;
			cache_data_i = model_word(cache_held);
			@(negedge clk);
			cache_wait = 1'b0;
			cache_ready_i = 1'b0;
		end
	end

	// store buffer reads the same array
	always begin
		@(negedge clk);
		if (stbuf_req_o === 1'b1) begin
			wait_stbuf_i = 1'b1;
			stbuf_held = stbuf_addr_o;
			@(negedge clk);
			stbuf_ready_i = 1'b1;
			stbuf_data_i = model_word(stbuf_held);
			@(negedge clk);
			wait_stbuf_i = 1'b0;
			stbuf_ready_i = 1'b0;
		end
	end

	`include "prefetcher_tests.svh"

	initial begin
		$timeformat(-9, 0, " ns", 0);
		errors = 0;
		timeouts = 0;
		reset = 1'b1;
		trigger_i = 1'b0;
		cache_wait = 1'b0;
		extra_stall = 1'b0;
		wait_stbuf_i = 1'b0;
		cache_ready_i = 1'b0;
		stbuf_ready_i = 1'b0;
		cache_data_i = '0;
		stbuf_data_i = '0;
		fill_model();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idle_after_reset();
		start_on_trigger();
		hold_under_stall();
		setup_store_pair();
		run_to_done();
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
